// ==== verilog/gfx_settings.svh ====
// Tile graphics sizes
// Map, tile ROM, VRAM and line buffer dimensions shared by RTL and testbench
`ifndef GFX_SETTINGS_SVH
`define GFX_SETTINGS_SVH

// Two maps of 32x32 tiles per VRAM
`define GFX_VRAM_AW 11

// Layer, 9-bit tile code, 3-bit tile row
`define GFX_ROM_AW 13

`define GFX_MAP_TILES 32

// One extra scr word covers the fine scroll
`define GFX_SCR_WORDS 33

// Line half bit plus word index
`define GFX_LINE_AW 7

// Clocks from hdump to pxl_out
`define GFX_PXL_LATENCY 3

`endif

// ==== verilog/gfx_regs_pkg.sv ====
// CPU side definitions of the tile graphics block
// Register indices and the decoded configuration
`default_nettype none

package gfx_regs_pkg;

    // Register index from cpu_addr[1:0]
    typedef enum logic [1:0] {
        REG_HSCROLL = 2'd0,
        REG_VSCROLL = 2'd1,
        REG_CTRL    = 2'd2
    } gfx_reg_e;

    // Decoded configuration
    typedef struct packed {
        logic [7:0] hscroll;
        logic [7:0] vscroll;
        logic [1:0] pal_bank;   // ctrl[1:0]
        logic       irq_en;     // ctrl[2]
        logic       chr_en;     // ctrl[3]
        logic       spare;      // ctrl[4]
    } gfx_cfg_t;

endpackage

`default_nettype wire

// ==== verilog/gfx_video_pkg.sv ====
// Video side definitions of the tile graphics block
// Rendered tile row and layer select
`default_nettype none

package gfx_video_pkg;

    // Eight 4-bit colour indices, pxl[0] is the leftmost pixel
    typedef struct packed {
        logic [2:0]      pal;
        logic [7:0][3:0] pxl;
    } gfx_row_t;

    // Layer select, matches VRAM address bit 10
    typedef enum logic {
        LYR_SCR = 1'b0,
        LYR_CHR = 1'b1
    } gfx_layer_e;

endpackage

`default_nettype wire

// ==== verilog/gfx_line_if.sv ====
// Line buffer write bus
// Renderer writes one tile row per strobe, no acknowledge
`timescale 1ns/1ps
`default_nettype none
`include "gfx_settings.svh"

interface gfx_line_if import gfx_video_pkg::*; ();

    logic                    chr_we;
    logic                    scr_we;
    logic [`GFX_LINE_AW-1:0] addr;
    gfx_row_t                row;
    // Half being written, the other half is on display
    logic                    half;

    modport renderer (output chr_we, output scr_we, output addr, output row, output half);

    modport store (input chr_we, input scr_we, input addr, input row, input half);

endinterface

`default_nettype wire

// ==== verilog/gfx_mmr.sv ====
// Configuration registers and vertical blank interrupt
// Holds hscroll, vscroll and ctrl and decodes them for the video side
`timescale 1ns/1ps
`default_nettype none

module gfx_mmr import gfx_regs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_we,
    input  logic       cfg_cs,
    input  logic [1:0] cpu_addr_lo,
    input  logic [7:0] cpu_din,
    input  logic       LHBL,
    input  logic       LVBL,
    output gfx_cfg_t   cfg,
    output logic       cpu_irqn
);

    logic [7:0] hscroll_q;
    logic [7:0] vscroll_q;
    logic [4:0] ctrl_q;
    logic       last_lvbl;

    always_ff @(posedge clk) begin
        if (rst) begin
            hscroll_q <= 8'd0;
            vscroll_q <= 8'd0;
            ctrl_q    <= 5'd0;
        end else if (cpu_we && cfg_cs) begin
            case (gfx_reg_e'(cpu_addr_lo))
                REG_HSCROLL: hscroll_q <= cpu_din;
                REG_VSCROLL: vscroll_q <= cpu_din;
                REG_CTRL:    ctrl_q    <= cpu_din[4:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        cfg.hscroll  = hscroll_q;
        cfg.vscroll  = vscroll_q;
        cfg.pal_bank = ctrl_q[1:0];
        cfg.irq_en   = ctrl_q[2];
        cfg.chr_en   = ctrl_q[3];
        cfg.spare    = ctrl_q[4];
    end

    // Set on LVBL fall, cleared once the next line starts
    always_ff @(posedge clk) begin
        if (rst) begin
            last_lvbl <= 1'b0;
            cpu_irqn  <= 1'b1;
        end else begin
            last_lvbl <= LVBL;
            if (last_lvbl && !LVBL && cfg.irq_en) begin
                cpu_irqn <= 1'b0;
            end else if (LHBL) begin
                cpu_irqn <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/gfx_dpram.sv ====
// Dual-port RAM with a generic payload
// Port one writes with read back, port two is a registered read
`timescale 1ns/1ps
`default_nettype none

module gfx_dpram #(
    parameter int  AW = 8,
    parameter type T  = logic [7:0]
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] wr_addr,
    input  T              din,
    input  logic [AW-1:0] rd_addr,
    output T              q_wr,
    output T              q_rd
);

    T mem [0:(1<<AW)-1];

    // Port one, read returns the old contents on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= din;
        end
        q_wr <= mem[wr_addr];
    end

    // Port two, read only
    always_ff @(posedge clk) begin
        q_rd <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/gfx_tilemap.sv ====
// Tile fetch and render engine
// Renders 32 chr words then 33 scr words of the next line into the hidden half
`timescale 1ns/1ps
`default_nettype none
`include "gfx_settings.svh"

module gfx_tilemap import gfx_regs_pkg::*, gfx_video_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    LHBL,
    input  logic [8:0]              vrender,
    input  gfx_cfg_t                cfg,
    output logic [`GFX_VRAM_AW-1:0] scan_addr,
    input  logic [7:0]              code_scan,
    input  logic [7:0]              attr_scan,
    output logic                    rom_cs,
    output logic [`GFX_ROM_AW-1:0]  rom_addr,
    input  logic                    rom_ok,
    input  logic [31:0]             rom_data,
    gfx_line_if.renderer            lbuf,
    output logic                    done
);

    typedef enum logic [2:0] {ST_IDLE, ST_SCAN, ST_VWAIT, ST_ROM, ST_WRITE} state_e;

    state_e     state;
    gfx_layer_e layer;
    logic       last_lhbl;
    logic       lhbl_fall;
    logic [5:0] scan_idx;
    logic [5:0] fetch_idx;
    logic [7:0] chr_v;
    logic [7:0] scr_v;
    logic [4:0] hs_coarse;
    logic [4:0] map_row;
    logic [4:0] map_col;
    logic [2:0] tile_row;
    logic [2:0] pal_q;
    logic       last_word;
    logic       issue;
    logic       accept;

    assign lhbl_fall = last_lhbl & ~LHBL;

    always_comb begin
        if (layer == LYR_CHR) begin
            map_row   = chr_v[7:3];
            map_col   = scan_idx[4:0];
            tile_row  = chr_v[2:0];
            last_word = fetch_idx == 6'(`GFX_MAP_TILES - 1);
        end else begin
            map_row   = scr_v[7:3];
            map_col   = hs_coarse + scan_idx[4:0];   // wraps around the map
            tile_row  = scr_v[2:0];
            last_word = fetch_idx == 6'(`GFX_SCR_WORDS - 1);
        end
        scan_addr = {layer, map_row, map_col};
        // Next scan is already settled while the ROM is busy
        issue  = !lhbl_fall && (state == ST_VWAIT || (state == ST_WRITE && !last_word));
        accept = !lhbl_fall && state == ST_ROM && rom_ok;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            layer       <= LYR_CHR;
            last_lhbl   <= 1'b0;
            scan_idx    <= 6'd0;
            rom_cs      <= 1'b0;
            done        <= 1'b0;
            lbuf.half   <= 1'b0;
            lbuf.chr_we <= 1'b0;
            lbuf.scr_we <= 1'b0;
        end else begin
            last_lhbl   <= LHBL;
            done        <= 1'b0;
            lbuf.chr_we <= accept && layer == LYR_CHR;
            lbuf.scr_we <= accept && layer == LYR_SCR;
            if (lhbl_fall) begin
                lbuf.half <= ~lbuf.half;
                layer     <= LYR_CHR;
                scan_idx  <= 6'd0;
                rom_cs    <= 1'b0;
                state     <= ST_SCAN;
            end else begin
                case (state)
                    ST_SCAN: state <= ST_VWAIT;
                    ST_ROM: begin
                        if (rom_ok) begin
                            rom_cs <= 1'b0;
                            state  <= ST_WRITE;
                        end
                    end
                    ST_WRITE: begin
                        if (last_word && layer == LYR_CHR) begin
                            layer    <= LYR_SCR;
                            scan_idx <= 6'd0;
                            state    <= ST_SCAN;
                        end else if (last_word) begin
                            done  <= 1'b1;
                            state <= ST_IDLE;
                        end
                    end
                    default: ;
                endcase
                if (issue) begin
                    rom_cs   <= 1'b1;
                    scan_idx <= scan_idx + 6'd1;
                    state    <= ST_ROM;
                end
            end
        end
    end

    // Line parameters and tile payload
    always_ff @(posedge clk) begin
        if (lhbl_fall) begin
            chr_v     <= vrender[7:0];
            scr_v     <= vrender[7:0] + cfg.vscroll;
            hs_coarse <= cfg.hscroll[7:3];
        end
        if (issue) begin
            rom_addr  <= {layer, attr_scan[7], code_scan, tile_row};
            pal_q     <= attr_scan[2:0];
            fetch_idx <= scan_idx;
        end
        if (accept) begin
            lbuf.row.pal <= pal_q;
            lbuf.row.pxl <= rom_data;
            lbuf.addr    <= {lbuf.half, fetch_idx};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/gfx_colmix.sv ====
// Layer mixer and colour PROM
// Reads the displayed line half, applies chr priority and maps through the PROM
`timescale 1ns/1ps
`default_nettype none
`include "gfx_settings.svh"

module gfx_colmix import gfx_regs_pkg::*, gfx_video_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [8:0]              hdump,
    input  logic                    line_half,
    input  gfx_cfg_t                cfg,
    output logic [`GFX_LINE_AW-1:0] rd_addr_chr,
    output logic [`GFX_LINE_AW-1:0] rd_addr_scr,
    input  gfx_row_t                chr_row,
    input  gfx_row_t                scr_row,
    input  logic [7:0]              prog_addr,
    input  logic [3:0]              prog_data,
    input  logic                    prom_we,
    output logic [6:0]              pxl_out
);

    logic [3:0] prom [0:255];
    logic [8:0] sx;
    logic [2:0] chr_sel;
    logic [2:0] scr_sel;
    logic [3:0] chr_nib;
    logic [3:0] scr_nib;
    gfx_layer_e lyr;
    logic [7:0] idx;
    logic [3:0] prom_q;

    // Stage 0, line buffer address of the shown half
    always_comb begin
        sx          = {1'b0, hdump[7:0]} + {6'd0, cfg.hscroll[2:0]};
        rd_addr_chr = {~line_half, 1'b0, hdump[7:3]};
        rd_addr_scr = {~line_half, sx[8:3]};
    end

    always_ff @(posedge clk) begin
        chr_sel <= hdump[2:0];
        scr_sel <= sx[2:0];
    end

    // Stage 1, priority, chr is transparent on zero
    always_comb begin
        chr_nib = chr_row.pxl[chr_sel];
        scr_nib = scr_row.pxl[scr_sel];
        lyr     = (cfg.chr_en && chr_nib != 4'd0) ? LYR_CHR : LYR_SCR;
        if (lyr == LYR_CHR) begin
            idx = {lyr, chr_row.pal, chr_nib};
        end else begin
            idx = {lyr, scr_row.pal, scr_nib};
        end
    end

    always_ff @(posedge clk) begin
        if (prom_we) begin
            prom[prog_addr] <= prog_data;
        end
        prom_q <= prom[idx];
    end

    // Stage 2, output register
    always_ff @(posedge clk) begin
        if (rst) begin
            pxl_out <= 7'h7f;
        end else begin
            pxl_out <= {cfg.pal_bank, 1'b1, prom_q};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/gfx_top.sv ====
// Two-layer tile graphics block
// CPU registers and VRAM, per-line renderer, line buffers and colour mixer
`timescale 1ns/1ps
`default_nettype none
`include "gfx_settings.svh"

module gfx_top import gfx_regs_pkg::*, gfx_video_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // CPU
    input  logic                   cpu_we,
    input  logic                   cfg_cs,
    input  logic                   vram_cs,
    input  logic [11:0]            cpu_addr,
    input  logic [7:0]             cpu_din,
    output logic [7:0]             gfx_dout,
    output logic                   cpu_irqn,
    // Video timing
    input  logic                   LHBL,
    input  logic                   LVBL,
    input  logic [8:0]             hdump,
    input  logic [8:0]             vrender,
    // Colour PROM load
    input  logic [7:0]             prog_addr,
    input  logic [3:0]             prog_data,
    input  logic                   prom_we,
    // Tile ROM
    output logic                   rom_cs,
    output logic [`GFX_ROM_AW-1:0] rom_addr,
    input  logic                   rom_ok,
    input  logic [31:0]            rom_data,
    output logic [6:0]             pxl_out
);

    gfx_cfg_t                cfg;
    logic [`GFX_VRAM_AW-1:0] vram_addr;
    logic [`GFX_VRAM_AW-1:0] scan_addr;
    logic                    code_we;
    logic                    attr_we;
    logic                    dout_code;
    logic [7:0]              code_dout;
    logic [7:0]              attr_dout;
    logic [7:0]              code_scan;
    logic [7:0]              attr_scan;
    logic [`GFX_LINE_AW-1:0] rd_addr_chr;
    logic [`GFX_LINE_AW-1:0] rd_addr_scr;
    gfx_row_t                chr_row;
    gfx_row_t                scr_row;
    logic                    done;

    gfx_line_if u_line();

    // Bit 11 picks code or attr, bit 10 picks the map
    assign vram_addr = {cpu_addr[10], cpu_addr[9:0]};
    assign code_we   = cpu_we & vram_cs &  cpu_addr[11];
    assign attr_we   = cpu_we & vram_cs & ~cpu_addr[11];

    // Read data follows the address by one clock
    always_ff @(posedge clk) begin
        dout_code <= cpu_addr[11];
    end

    assign gfx_dout = dout_code ? code_dout : attr_dout;

    gfx_mmr u_mmr (
        .clk         ( clk           ),
        .rst         ( rst           ),
        .cpu_we      ( cpu_we        ),
        .cfg_cs      ( cfg_cs        ),
        .cpu_addr_lo ( cpu_addr[1:0] ),
        .cpu_din     ( cpu_din       ),
        .LHBL        ( LHBL          ),
        .LVBL        ( LVBL          ),
        .cfg         ( cfg           ),
        .cpu_irqn    ( cpu_irqn      )
    );

    gfx_dpram #(.AW(`GFX_VRAM_AW), .T(logic [7:0])) u_code_ram (
        .clk     ( clk       ),
        .we      ( code_we   ),
        .wr_addr ( vram_addr ),
        .din     ( cpu_din   ),
        .rd_addr ( scan_addr ),
        .q_wr    ( code_dout ),
        .q_rd    ( code_scan )
    );

    gfx_dpram #(.AW(`GFX_VRAM_AW), .T(logic [7:0])) u_attr_ram (
        .clk     ( clk       ),
        .we      ( attr_we   ),
        .wr_addr ( vram_addr ),
        .din     ( cpu_din   ),
        .rd_addr ( scan_addr ),
        .q_wr    ( attr_dout ),
        .q_rd    ( attr_scan )
    );

    gfx_tilemap u_tilemap (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .LHBL      ( LHBL      ),
        .vrender   ( vrender   ),
        .cfg       ( cfg       ),
        .scan_addr ( scan_addr ),
        .code_scan ( code_scan ),
        .attr_scan ( attr_scan ),
        .rom_cs    ( rom_cs    ),
        .rom_addr  ( rom_addr  ),
        .rom_ok    ( rom_ok    ),
        .rom_data  ( rom_data  ),
        .lbuf      ( u_line    ),
        .done      ( done      )
    );

    gfx_dpram #(.AW(`GFX_LINE_AW), .T(gfx_row_t)) u_line_chr (
        .clk     ( clk           ),
        .we      ( u_line.chr_we ),
        .wr_addr ( u_line.addr   ),
        .din     ( u_line.row    ),
        .rd_addr ( rd_addr_chr   ),
        .q_wr    (               ),
        .q_rd    ( chr_row       )
    );

    gfx_dpram #(.AW(`GFX_LINE_AW), .T(gfx_row_t)) u_line_scr (
        .clk     ( clk           ),
        .we      ( u_line.scr_we ),
        .wr_addr ( u_line.addr   ),
        .din     ( u_line.row    ),
        .rd_addr ( rd_addr_scr   ),
        .q_wr    (               ),
        .q_rd    ( scr_row       )
    );

    gfx_colmix u_colmix (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .hdump       ( hdump       ),
        .line_half   ( u_line.half ),
        .cfg         ( cfg         ),
        .rd_addr_chr ( rd_addr_chr ),
        .rd_addr_scr ( rd_addr_scr ),
        .chr_row     ( chr_row     ),
        .scr_row     ( scr_row     ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prom_we     ( prom_we     ),
        .pxl_out     ( pxl_out     )
    );

endmodule

`default_nettype wire

// ==== tb/gfx_assertions.sv ====
// Concurrent checks on the renderer handshakes and the interrupt
// Render deadline, tile ROM address hold and interrupt clear
`timescale 1ns/1ps
`default_nettype none
`include "gfx_settings.svh"

module gfx_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   LHBL,
    input logic                   rom_cs,
    input logic [`GFX_ROM_AW-1:0] rom_addr,
    input logic                   rom_ok,
    input logic                   done,
    input logic                   cpu_irqn
);

    logic last_lhbl;
    logic rendering;

    // Render in progress from an LHBL fall until done
    always_ff @(posedge clk) begin
        if (rst) begin
            last_lhbl <= 1'b1;
            rendering <= 1'b0;
        end else begin
            last_lhbl <= LHBL;
            if (last_lhbl && !LHBL) begin
                rendering <= 1'b1;
            end else if (done) begin
                rendering <= 1'b0;
            end
        end
    end

    render_deadline: assert property (@(posedge clk) disable iff (rst)
        (last_lhbl && !LHBL) |-> !rendering)
        else $error("render still busy at the next LHBL fall");

    rom_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (rom_cs && !rom_ok) |=> $stable(rom_addr))
        else $error("rom_addr changed while rom_cs waited for rom_ok");

    irq_clear: assert property (@(posedge clk) disable iff (rst)
        (!cpu_irqn && LHBL) |=> cpu_irqn)
        else $error("cpu_irqn stayed low with LHBL high");

endmodule

`default_nettype wire

// ==== tb/gfx_tb.sv ====
// Testbench for the tile graphics block
// Video timing, tile ROM model, reference pixels and table-driven checks
`timescale 1ns/1ps
`default_nettype none
`include "gfx_settings.svh"

module gfx_tb;

    localparam int NUM_TESTS  = 8;
    localparam int WAIT_LIMIT = 262 * 512 * 2;

    logic        clk;
    logic        rst;
    logic        cpu_we;
    logic        cfg_cs;
    logic        vram_cs;
    logic [11:0] cpu_addr;
    logic [7:0]  cpu_din;
    logic [7:0]  gfx_dout;
    logic        cpu_irqn;
    logic        LHBL;
    logic        LVBL;
    logic [8:0]  hdump;
    logic [8:0]  vdump;
    logic [8:0]  vrender;
    logic [7:0]  prog_addr;
    logic [3:0]  prog_data;
    logic        prom_we;
    logic        rom_cs;
    logic [`GFX_ROM_AW-1:0] rom_addr;
    logic        rom_ok;
    logic [31:0] rom_data;
    logic [6:0]  pxl_out;

    // ROM model state
    logic        rom_busy;
    logic [1:0]  rom_wait;

    // Mirrors of everything written through the CPU ports
    logic [7:0] code_m [0:2047];
    logic [7:0] attr_m [0:2047];
    logic [3:0] prom_m [0:255];

    // Test table
    string      names    [NUM_TESTS];
    logic [7:0] hs_tab   [NUM_TESTS];
    logic [7:0] vs_tab   [NUM_TESTS];
    logic [7:0] ctrl_tab [NUM_TESTS];
    int         pat_tab  [NUM_TESTS];
    int         line_tab [NUM_TESTS];

    int errors;
    int timeouts;

    gfx_top UUT (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cpu_we    ( cpu_we    ),
        .cfg_cs    ( cfg_cs    ),
        .vram_cs   ( vram_cs   ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_din   ( cpu_din   ),
        .gfx_dout  ( gfx_dout  ),
        .cpu_irqn  ( cpu_irqn  ),
        .LHBL      ( LHBL      ),
        .LVBL      ( LVBL      ),
        .hdump     ( hdump     ),
        .vrender   ( vrender   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prom_we   ( prom_we   ),
        .rom_cs    ( rom_cs    ),
        .rom_addr  ( rom_addr  ),
        .rom_ok    ( rom_ok    ),
        .rom_data  ( rom_data  ),
        .pxl_out   ( pxl_out   )
    );

    bind gfx_top gfx_assertions u_assertions (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .LHBL     ( LHBL     ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_ok   ( rom_ok   ),
        .done     ( done     ),
        .cpu_irqn ( cpu_irqn )
    );

    always #5 clk = ~clk;

    // 512 clocks per line and 262 lines
    // Vertical blank starts in the hblank before line 240
    always @(posedge clk) begin
        if (rst) begin
            hdump   <= 9'd0;
            vdump   <= 9'd0;
            vrender <= 9'd1;
            LHBL    <= 1'b1;
            LVBL    <= 1'b1;
        end else if (hdump == 9'd511) begin
            hdump   <= 9'd0;
            LHBL    <= 1'b1;
            vdump   <= (vdump == 9'd261) ? 9'd0 : vdump + 9'd1;
            vrender <= (vdump == 9'd261) ? 9'd1 : vdump + 9'd2;
        end else begin
            hdump <= hdump + 9'd1;
            if (hdump == 9'd255) begin
                LHBL <= 1'b0;
                LVBL <= !(vdump >= 9'd239 && vdump <= 9'd260);
            end
        end
    end

    // Tile ROM data is a fixed function of the address
    // About a quarter of the nibbles are zero
    function automatic logic [31:0] rom_word(input logic [12:0] a);
        logic [31:0] w;
        int          n;
        for (int k = 0; k < 8; k++) begin
            n = (int'(a[7:0]) + k * 5 + int'(a[12:8]) * 3) % 11;
            w[4*k +: 4] = (n < 3) ? 4'd0 : 4'(n + 4);
        end
        return w;
    endfunction

    // Answers 1 to 3 cycles after rom_cs is seen
    always @(posedge clk) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
            rom_wait <= 2'd0;
            rom_data <= 32'd0;
        end else if (rom_ok) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else if (rom_cs) begin
            if (!rom_busy) begin
                rom_busy <= 1'b1;
                rom_wait <= 2'($urandom_range(3, 1) - 1);
            end else if (rom_wait == 2'd0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word(rom_addr);
            end else begin
                rom_wait <= rom_wait - 2'd1;
            end
        end else begin
            rom_busy <= 1'b0;
        end
    end

    function automatic logic [7:0] fill_byte(input logic [11:0] a, input int pat);
        logic [11:0] t;
        t = (a * 12'd29) ^ (a >> 4) ^ 12'(pat * 91);
        return t[7:0] ^ a[11:4];
    endfunction

    // Reference pixel for screen column x on a given line
    function automatic logic [6:0] expected_pixel(input int x, input int line,
            input logic [7:0] hs, input logic [7:0] vs, input logic [7:0] ctrl);
        logic [7:0]  r;
        logic [7:0]  sv;
        logic [8:0]  sx;
        logic [4:0]  col;
        logic [10:0] va;
        logic [12:0] ra;
        logic [31:0] w;
        logic [3:0]  cn;
        logic [3:0]  sn;
        logic [2:0]  cp;
        logic [2:0]  sp;
        logic [7:0]  idx;
        // Line L shows the tile row rendered one period earlier
        r  = 8'(line - 1);
        va = {1'b1, r[7:3], 5'(x / 8)};
        ra = {1'b1, attr_m[va][7], code_m[va], r[2:0]};
        w  = rom_word(ra);
        cn = w[4*(x%8) +: 4];
        cp = attr_m[va][2:0];
        sx  = 9'(x) + {6'd0, hs[2:0]};
        sv  = r + vs;
        col = hs[7:3] + sx[7:3];
        va  = {1'b0, sv[7:3], col};
        ra  = {1'b0, attr_m[va][7], code_m[va], sv[2:0]};
        w   = rom_word(ra);
        sn  = w[4*int'(sx[2:0]) +: 4];
        sp  = attr_m[va][2:0];
        if (ctrl[3] && cn != 4'd0) begin
            idx = {1'b1, cp, cn};
        end else begin
            idx = {1'b0, sp, sn};
        end
        return {ctrl[1:0], 1'b1, prom_m[idx]};
    endfunction

    task automatic expect_equal(input string test, input string what,
            input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp) else begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", test, what, exp, act);
        end
    endtask

    // Fills one row of the test table
    task automatic define_test(input int i, input string name, input logic [7:0] hs,
            input logic [7:0] vs, input logic [7:0] ctrl, input int pat, input int line);
        names[i]    = name;
        hs_tab[i]   = hs;
        vs_tab[i]   = vs;
        ctrl_tab[i] = ctrl;
        pat_tab[i]  = pat;
        line_tab[i] = line;
    endtask

    // Loads VRAM, PROM and registers for one table entry
    task automatic program_all(input int i);
        for (int a = 0; a < 4096; a++) begin
            @(posedge clk);
            vram_cs  <= 1'b1;
            cpu_we   <= 1'b1;
            cpu_addr <= 12'(a);
            cpu_din  <= fill_byte(12'(a), pat_tab[i]);
            if (a >= 2048) begin
                code_m[a - 2048] = fill_byte(12'(a), pat_tab[i]);
            end else begin
                attr_m[a] = fill_byte(12'(a), pat_tab[i]);
            end
        end
        for (int p = 0; p < 256; p++) begin
            @(posedge clk);
            vram_cs   <= 1'b0;
            cpu_we    <= 1'b0;
            prom_we   <= 1'b1;
            prog_addr <= 8'(p);
            prog_data <= 4'((p * 7 + pat_tab[i] * 3 + p / 16) % 16);
            prom_m[p] = 4'((p * 7 + pat_tab[i] * 3 + p / 16) % 16);
        end
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            prom_we  <= 1'b0;
            cfg_cs   <= 1'b1;
            cpu_we   <= 1'b1;
            cpu_addr <= 12'(k);
            cpu_din  <= (k == 0) ? hs_tab[i] : (k == 1) ? vs_tab[i] : ctrl_tab[i];
        end
        @(posedge clk);
        cfg_cs <= 1'b0;
        cpu_we <= 1'b0;
    endtask

    task automatic check_readback(input int i);
        logic [11:0] a;
        for (int k = 0; k < 8; k++) begin
            a = 12'(k * 517 + 3);
            @(posedge clk);
            vram_cs  <= 1'b1;
            cpu_we   <= 1'b0;
            cpu_addr <= a;
            @(posedge clk);
            vram_cs <= 1'b0;
            @(negedge clk);
            expect_equal(names[i], $sformatf("readback %h", a),
                32'(a[11] ? code_m[a[10:0]] : attr_m[a[10:0]]), 32'(gfx_dout));
        end
    endtask

    task automatic wait_position(input int v, input int h, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!(int'(vdump) == v && int'(hdump) == h) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            timeouts++;
            $display("Timeout: %s, video never reached line %0d", what, v);
        end
    endtask

    task automatic wait_lvbl_fall(input string what);
        int   n;
        logic prev;
        n    = 0;
        prev = LVBL;
        @(negedge clk);
        while (!(prev && !LVBL) && n < WAIT_LIMIT) begin
            prev = LVBL;
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            timeouts++;
            $display("Timeout: %s, vertical blank never started", what);
        end
    endtask

    task automatic wait_lhbl_high(input string what);
        int n;
        n = 0;
        while (!LHBL && n < 1024) begin
            @(negedge clk);
            n++;
        end
        if (n >= 1024) begin
            timeouts++;
            $display("Timeout: %s, LHBL never went high", what);
        end
    endtask

    task automatic run_entry(input int i);
        int line;
        line = line_tab[i];
        program_all(i);
        if (i == 0) begin
            check_readback(i);
        end
        // Render of the checked row must start after all writes
        wait_position(line - 2, 0, names[i]);
        wait_position(line, `GFX_PXL_LATENCY, names[i]);
        if (timeouts == 0) begin
            for (int x = 0; x < 256; x++) begin
                expect_equal(names[i], $sformatf("line %0d pixel %0d", line, x),
                    32'(expected_pixel(x, line, hs_tab[i], vs_tab[i], ctrl_tab[i])),
                    32'(pxl_out));
                @(negedge clk);
            end
        end
        wait_lvbl_fall(names[i]);
        @(negedge clk);
        expect_equal(names[i], "cpu_irqn after LVBL fall", 32'(!ctrl_tab[i][2]),
            32'(cpu_irqn));
        wait_lhbl_high(names[i]);
        @(negedge clk);
        expect_equal(names[i], "cpu_irqn after LHBL high", 32'd1, 32'(cpu_irqn));
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        cpu_we    = 1'b0;
        cfg_cs    = 1'b0;
        vram_cs   = 1'b0;
        cpu_addr  = 12'd0;
        cpu_din   = 8'd0;
        prog_addr = 8'd0;
        prog_data = 4'd0;
        prom_we   = 1'b0;
        hdump     = 9'd0;
        vdump     = 9'd0;
        vrender   = 9'd1;
        LHBL      = 1'b1;
        LVBL      = 1'b1;
        rom_ok    = 1'b0;
        rom_data  = 32'd0;
        errors    = 0;
        timeouts  = 0;
        void'($urandom(62));

        // Fine scroll values 0 to 7 are all covered
        define_test(0, "chr_over_scr", 8'h00, 8'h00, 8'h09, 1, 20);
        define_test(1, "scr_only", 8'h13, 8'h05, 8'h02, 2, 100);
        define_test(2, "fine_scroll_irq", 8'h05, 8'h31, 8'h0f, 3, 57);
        define_test(3, "wrap_scroll", 8'hff, 8'hf0, 8'h0e, 4, 200);
        define_test(4, "fine_scroll_1", 8'h21, 8'h77, 8'h0d, 5, 33);
        define_test(5, "fine_scroll_2", 8'h4a, 8'h18, 8'h03, 6, 150);
        define_test(6, "fine_scroll_4", 8'h9c, 8'hc3, 8'h0b, 7, 7);
        define_test(7, "fine_scroll_6", 8'he6, 8'h09, 8'h06, 8, 230);

        // Reset values, sampled while reset is still applied
        repeat (2) @(posedge clk);
        @(negedge clk);
        expect_equal("reset", "pxl_out", 32'h7f, 32'(pxl_out));
        expect_equal("reset", "cpu_irqn", 32'd1, 32'(cpu_irqn));
        expect_equal("reset", "rom_cs", 32'd0, 32'(rom_cs));
        @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            if (timeouts == 0) begin
                run_entry(i);
            end
        end

        $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/gfx_regs_pkg.sv
verilog/gfx_video_pkg.sv
verilog/gfx_line_if.sv
verilog/gfx_mmr.sv
verilog/gfx_dpram.sv
verilog/gfx_tilemap.sv
verilog/gfx_colmix.sv
verilog/gfx_top.sv
tb/gfx_assertions.sv
tb/gfx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the tile graphics testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module gfx_tb -o gfx_sim

sim_output=$(./obj_dir/gfx_sim)
echo "$sim_output"

if grep -q "TEST RESULT: PASS" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi
